// File: src.f
rtl/read_datapath_pkg.sv
rtl/read_latency_fifo.sv
rtl/oct_ctrl.sv
rtl/rdata_mapper.sv
rtl/read_datapath.sv
verif/tb_read_datapath.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and grade the log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_read_datapath -f src.f -o tb_read_datapath_sim \
	&& ./obj_dir/tb_read_datapath_sim > sim.log 2>&1
[ -f sim.log ] && cat sim.log
grep -q "^=== PASS ===$" sim.log \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }

// File: verif/tb_read_datapath.sv
`default_nettype none

module tb_read_datapath;

	import read_datapath_pkg::*;

	// ********************
	// Configuration
	// ********************

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 8;
	localparam int EXTRA_SHIFT = 2;
	localparam int T_RL = 11;

	// Termination window edges for a read latency of 11
	localparam int OCT_ON_DELAY = 3;
	localparam int OCT_OFF_DELAY = 8;

	// Cycles spent by each test, used to size the watchdog
	localparam int T_RESET_LEN = 4;
	localparam int T_DATA_LEN = 210;
	localparam int T_VALID_LEN = 430;
	localparam int T_B2B_LEN = 50;
	localparam int T_OCT_LEN = 130;
	localparam int TOTAL_CYCLES = RESET_CYCLES + T_RESET_LEN + T_DATA_LEN + T_VALID_LEN
		+ T_B2B_LEN + T_OCT_LEN;
	localparam int WATCHDOG_TIME = 2 * TOTAL_CYCLES * CLK_PERIOD;

	// Far more entries than edges the watchdog allows
	localparam int HIST_DEPTH = 4096;

	logic       pll_afi_clk;
	logic       reset_n_afi_clk;
	afi_data_t  ddio_phy_dq_i;
	rate_mask_t afi_rdata_en_i;
	rate_mask_t afi_rdata_en_full_i;
	lat_cnt_t   seq_read_latency_counter_i;
	afi_data_t  afi_rdata_o;
	afi_data_t  phy_mux_read_fifo_q_o;
	rate_mask_t afi_rdata_valid_o;
	oct_mask_t  force_oct_off_o;

	// Per-edge record of what the DUT sampled, index is the edge number
	bit         rst_hist [HIST_DEPTH];
	bit         en_hist [HIST_DEPTH];
	bit         full_hist [HIST_DEPTH];
	lat_cnt_t   lat_hist [HIST_DEPTH];
	int         edge_cnt;

	logic [31:0] lfsr_state;
	bit          checking;
	string       test_name;
	int          err_count;
	int          test_start_errs;
	int          tests_passed;
	int          tests_failed;

	read_datapath #(
		.EXTRA_VFIFO_SHIFT (EXTRA_SHIFT),
		.MEM_T_RL          (T_RL)
	) read_datapath_i (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.ddio_phy_dq_i              (ddio_phy_dq_i),
		.afi_rdata_en_i             (afi_rdata_en_i),
		.afi_rdata_en_full_i        (afi_rdata_en_full_i),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.afi_rdata_o                (afi_rdata_o),
		.phy_mux_read_fifo_q_o      (phy_mux_read_fifo_q_o),
		.afi_rdata_valid_o          (afi_rdata_valid_o),
		.force_oct_off_o            (force_oct_off_o)
	);

	always #(CLK_PERIOD / 2) pll_afi_clk = ~pll_afi_clk;

	// Inputs change one unit after the edge, so here they are settled
	always @(posedge pll_afi_clk)
	begin
		edge_cnt = edge_cnt + 1;
		rst_hist[edge_cnt] = reset_n_afi_clk;
		// Flops ignore the inputs while reset is held
		en_hist[edge_cnt] = reset_n_afi_clk & afi_rdata_en_i[0];
		full_hist[edge_cnt] = reset_n_afi_clk & afi_rdata_en_full_i[0];
		lat_hist[edge_cnt] = seq_read_latency_counter_i;
	end

	// ********************
	// Reference model
	// ********************

	// 32-bit Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// Steps the LFSR once per bit and shifts each new bit in at the bottom
	task automatic take_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[62:0], lfsr_state[0]};
		end
	endtask

	// Group-major capture word to slot-major AFI word
	function automatic afi_data_t expected_rdata(afi_data_t cap);
		afi_data_t r;
		r = '0;
		for (int g = 0; g < MEM_READ_DQS_WIDTH; g++)
			for (int t = 0; t < NUM_TIMESLOTS; t++)
				r[t*MEM_DQ_WIDTH + g*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] =
					cap[g*NUM_TIMESLOTS*DQ_GROUP_WIDTH + t*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH];
		return r;
	endfunction

	// With the FIFOs in the I/O blocks the sequencer sees the capture word as it is
	function automatic afi_data_t expected_seq_copy(afi_data_t cap);
		return cap;
	endfunction

	// Valid after edge n shows enable bit 0 from S + L + 2 edges earlier
	// L is the counter the tap selector saw one edge before
	function automatic rate_mask_t expected_valid(int n);
		int idx;
		if (n < 1 || !rst_hist[n])
			return '0;
		idx = n - 2 - EXTRA_SHIFT - int'(lat_hist[n-1]);
		if (idx < 0)
			return '0;
		return {AFI_RATE_RATIO{en_hist[idx]}};
	endfunction

	// Termination is forced off unless a full enable sits in the window
	function automatic oct_mask_t expected_oct(int n);
		bit hit;
		hit = 1'b0;
		if (!rst_hist[n])
			return '0;
		for (int m = n - 1 - OCT_OFF_DELAY; m <= n - 1 - OCT_ON_DELAY; m++)
			if (m >= 0 && full_hist[m])
				hit = 1'b1;
		return {AFI_DQS_WIDTH{~hit}};
	endfunction

	// ********************
	// Compare tasks
	// ********************

	task automatic check_data(string what, afi_data_t exp, afi_data_t act);
		if (exp !== act)
		begin
			err_count++;
			$display("FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_valid(string what, rate_mask_t exp, rate_mask_t act);
		if (exp !== act)
		begin
			err_count++;
			$display("FAILED %s %s: expected %b actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic check_oct(string what, oct_mask_t exp, oct_mask_t act);
		if (exp !== act)
		begin
			err_count++;
			$display("FAILED %s %s: expected %b actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic check_count(string what, int exp, int act);
		if (exp != act)
		begin
			err_count++;
			$display("FAILED %s %s: expected %0d actual %0d", test_name, what, exp, act);
		end
	endtask

	// Outputs have settled by the falling edge half a period after the drive
	always @(negedge pll_afi_clk)
	begin
		if (checking)
		begin
			check_data("afi_rdata", expected_rdata(ddio_phy_dq_i), afi_rdata_o);
			check_data("seq copy", expected_seq_copy(ddio_phy_dq_i), phy_mux_read_fifo_q_o);
			check_valid("afi_rdata_valid", expected_valid(edge_cnt), afi_rdata_valid_o);
			check_oct("force_oct_off", expected_oct(edge_cnt), force_oct_off_o);
		end
	end

	// ********************
	// Tests
	// ********************

	task automatic next_cycle();
		@(posedge pll_afi_clk);
		#1;
	endtask

	task automatic begin_test(string name);
		test_name = name;
		test_start_errs = err_count;
	endtask

	task automatic end_test();
		int errs;
		errs = err_count - test_start_errs;
		if (errs == 0)
		begin
			tests_passed++;
			$display("test %s passed", test_name);
		end
		else
		begin
			tests_failed++;
			$display("test %s failed with %0d mismatches", test_name, errs);
		end
	endtask

	task automatic test_reset();
		begin_test("reset");
		// Read enables stay high during reset, so the valid path must hold them off
		afi_rdata_en_i = '1;
		repeat (RESET_CYCLES - 1) @(posedge pll_afi_clk);
		@(negedge pll_afi_clk);
		check_valid("valid in reset", '0, afi_rdata_valid_o);
		check_oct("oct in reset", '0, force_oct_off_o);
		checking = 1'b1;
		@(posedge pll_afi_clk);
		#1;
		reset_n_afi_clk = 1'b1;
		afi_rdata_en_i = '0;
		// First edge after release turns termination off with no reads pending
		@(negedge pll_afi_clk);
		@(negedge pll_afi_clk);
		check_oct("oct after release", '1, force_oct_off_o);
		end_test();
	endtask

	task automatic test_data();
		logic [63:0] w;
		begin_test("data_remap");
		for (int i = 0; i < 200; i++)
		begin
			next_cycle();
			take_bits(64, w);
			ddio_phy_dq_i = w;
		end
		end_test();
	endtask

	task automatic test_valid_latency();
		lat_cnt_t    lat_values [3];
		logic [63:0] r;
		lat_values = '{5'd0, 5'd5, 5'd31};
		begin_test("valid_latency");
		for (int i = 0; i < 3; i++)
		begin
			next_cycle();
			seq_read_latency_counter_i = lat_values[i];
			afi_rdata_en_i = 2'b00;
			for (int c = 0; c < 100; c++)
			begin
				next_cycle();
				take_bits(2, r);
				afi_rdata_en_i = r[1:0];
			end
			// Drain the pipeline before the counter moves
			next_cycle();
			afi_rdata_en_i = 2'b00;
			repeat (40) next_cycle();
		end
		end_test();
	endtask

	task automatic test_back_to_back();
		int start_edge;
		int first;
		int last;
		int count;
		begin_test("back_to_back");
		start_edge = 0;
		first = -1;
		last = -1;
		count = 0;
		next_cycle();
		// Latency of 14 cycles keeps all eight reads in flight at once
		seq_read_latency_counter_i = 5'd10;
		for (int c = 0; c < 40; c++)
		begin
			next_cycle();
			if (c == 0)
				start_edge = edge_cnt + 1;
			afi_rdata_en_i = (c < 8) ? 2'b11 : 2'b00;
			@(negedge pll_afi_clk);
			if (afi_rdata_valid_o[0])
			begin
				if (count == 0)
					first = edge_cnt;
				last = edge_cnt;
				count++;
			end
		end
		check_count("valid cycles", 8, count);
		check_count("first valid edge", start_edge + EXTRA_SHIFT + 10 + 2, first);
		check_count("valid run length", 8, last - first + 1);
		end_test();
	endtask

	// Drives full-enable pulses at two offsets and counts cycles with termination on
	task automatic run_full_pattern(input int first, input int second, input int cycles,
		output int low_cycles);
		low_cycles = 0;
		for (int c = 0; c < cycles; c++)
		begin
			next_cycle();
			afi_rdata_en_full_i = (c == first || c == second) ? 2'b11 : 2'b00;
			@(negedge pll_afi_clk);
			if (force_oct_off_o == '0)
				low_cycles++;
		end
	endtask

	task automatic test_oct_window();
		logic [63:0] r;
		int          low_cycles;
		begin_test("oct_window");
		run_full_pattern(0, -1, 16, low_cycles);
		check_count("single pulse window", OCT_OFF_DELAY - OCT_ON_DELAY + 1, low_cycles);
		// Second pulse three cycles later stretches the window by three
		run_full_pattern(0, 3, 20, low_cycles);
		check_count("overlap window", OCT_OFF_DELAY - OCT_ON_DELAY + 4, low_cycles);
		run_full_pattern(0, 1, 16, low_cycles);
		check_count("adjacent window", OCT_OFF_DELAY - OCT_ON_DELAY + 2, low_cycles);
		// Sparse random pulses are left to the per-cycle checker
		for (int c = 0; c < 60; c++)
		begin
			next_cycle();
			take_bits(3, r);
			afi_rdata_en_full_i = (r[2:0] == 3'b111) ? 2'b11 : 2'b00;
		end
		next_cycle();
		afi_rdata_en_full_i = 2'b00;
		end_test();
	endtask

	initial
	begin
		#(WATCHDOG_TIME);
		$display("Simulation timed out after %0d time units", WATCHDOG_TIME);
		$display("=== FAIL ===");
		$finish;
	end

	initial
	begin
		pll_afi_clk = 1'b0;
		reset_n_afi_clk = 1'b0;
		ddio_phy_dq_i = '0;
		afi_rdata_en_i = '0;
		afi_rdata_en_full_i = '0;
		seq_read_latency_counter_i = '0;
		edge_cnt = 0;
		lfsr_state = 32'h1de5_77e7;
		checking = 1'b0;
		err_count = 0;
		tests_passed = 0;
		tests_failed = 0;

		test_reset();
		test_data();
		test_valid_latency();
		test_back_to_back();
		test_oct_window();

		next_cycle();
		@(negedge pll_afi_clk);
		checking = 1'b0;
		$display("tests passed %0d, tests failed %0d, mismatches %0d",
			tests_passed, tests_failed, err_count);
		if (tests_failed == 0 && err_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/read_datapath.sv
`default_nettype none

// AFI clock side of the DDR3 PHY read path
// The read FIFOs live in the I/O blocks, so data arrives already on pll_afi_clk
module read_datapath #(
	// Extra AFI cycles in front of the read valid shifter
	parameter int EXTRA_VFIFO_SHIFT = 0,

	// Memory read latency in memory clocks, sets the termination window
	parameter int MEM_T_RL = 11
) (
	input  logic                          pll_afi_clk,
	input  logic                          reset_n_afi_clk,

	// Capture bus from the I/O FIFOs, group-major
	input  read_datapath_pkg::afi_data_t  ddio_phy_dq_i,

	// Read enables from the controller, one bit per phase
	input  read_datapath_pkg::rate_mask_t afi_rdata_en_i,
	input  read_datapath_pkg::rate_mask_t afi_rdata_en_full_i,

	// Calibrated read latency, static once calibration finishes
	input  read_datapath_pkg::lat_cnt_t   seq_read_latency_counter_i,

	// Read data toward the controller, slot-major
	output read_datapath_pkg::afi_data_t  afi_rdata_o,

	// Read data toward the sequencer, group-major
	output read_datapath_pkg::afi_data_t  phy_mux_read_fifo_q_o,

	output read_datapath_pkg::rate_mask_t afi_rdata_valid_o,
	output read_datapath_pkg::oct_mask_t  force_oct_off_o
);

	// ********************
	// Read valid path
	// ********************

	// Turns each read enable into a valid at the calibrated latency
	read_latency_fifo #(
		.EXTRA_VFIFO_SHIFT (EXTRA_VFIFO_SHIFT)
	) read_latency_fifo_i (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.afi_rdata_en_i             (afi_rdata_en_i),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.afi_rdata_valid_o          (afi_rdata_valid_o)
	);

	// ********************
	// Termination control
	// ********************

	// Keeps on-die termination enabled only around read bursts
	oct_ctrl #(
		.MEM_T_RL (MEM_T_RL)
	) oct_ctrl_i (
		.pll_afi_clk         (pll_afi_clk),
		.reset_n_afi_clk     (reset_n_afi_clk),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.force_oct_off_o     (force_oct_off_o)
	);

	// ********************
	// Read data ordering
	// ********************

	// Pure reordering with no clock, data passes in the same cycle
	rdata_mapper rdata_mapper_i (
		.ddio_phy_dq_i         (ddio_phy_dq_i),
		.afi_rdata_o           (afi_rdata_o),
		.phy_mux_read_fifo_q_o (phy_mux_read_fifo_q_o)
	);

endmodule

`default_nettype wire

// File: rtl/rdata_mapper.sv
`default_nettype none

module rdata_mapper (
	input  read_datapath_pkg::afi_data_t ddio_phy_dq_i,
	output read_datapath_pkg::afi_data_t afi_rdata_o,
	output read_datapath_pkg::afi_data_t phy_mux_read_fifo_q_o
);

	import read_datapath_pkg::*;

	// All time slots of one DQS group in the group-major layout
	localparam int GROUP_DATA_WIDTH = NUM_TIMESLOTS * DQ_GROUP_WIDTH;

	// ********************
	// Slice reordering
	// ********************

	// The capture bus comes out of the I/O FIFOs grouped by DQS group
	// Inside each group the slices run from slot 0 upwards
	//   G1_T3 G1_T2 G1_T1 G1_T0 G0_T3 G0_T2 G0_T1 G0_T0
	// The AFI wants all groups of one slot together, oldest slot lowest
	//   G1_T3 G0_T3 G1_T2 G0_T2 G1_T1 G0_T1 G1_T0 G0_T0
	// The sequencer copy goes back to the group-major layout
	generate
		for (genvar g = 0; g < MEM_READ_DQS_WIDTH; g++)
		begin : g_group
			for (genvar t = 0; t < NUM_TIMESLOTS; t++)
			begin : g_slot
				// Position of this slice in the group-major layout
				localparam int GROUP_MAJOR_LSB = g * GROUP_DATA_WIDTH + t * DQ_GROUP_WIDTH;

				// Position of this slice in the slot-major layout
				localparam int SLOT_MAJOR_LSB = t * MEM_DQ_WIDTH + g * DQ_GROUP_WIDTH;

				// Group g at slot t as it leaves the capture FIFO
				logic [DQ_GROUP_WIDTH-1:0] capture_slice;

				// The same beat as the AFI presents it
				logic [DQ_GROUP_WIDTH-1:0] afi_slice;

				assign capture_slice = ddio_phy_dq_i[GROUP_MAJOR_LSB +: DQ_GROUP_WIDTH];
				assign afi_rdata_o[SLOT_MAJOR_LSB +: DQ_GROUP_WIDTH] = capture_slice;

				// Sequencer copy is taken from the AFI bus so it always
				// matches what the controller sees
				assign afi_slice = afi_rdata_o[SLOT_MAJOR_LSB +: DQ_GROUP_WIDTH];
				assign phy_mux_read_fifo_q_o[GROUP_MAJOR_LSB +: DQ_GROUP_WIDTH] = afi_slice;
			end
		end
	endgenerate

endmodule

`default_nettype wire

// File: rtl/oct_ctrl.sv
`default_nettype none

module oct_ctrl #(
	parameter int MEM_T_RL = 11
) (
	input  logic                          pll_afi_clk,
	input  logic                          reset_n_afi_clk,
	input  read_datapath_pkg::rate_mask_t afi_rdata_en_full_i,
	output read_datapath_pkg::oct_mask_t  force_oct_off_o
);

	import read_datapath_pkg::*;

	// Window edges in AFI cycles, derived from the memory read latency
	// Termination turns on a little before the burst and off after it
	localparam int OCT_ON_DELAY  = (MEM_T_RL > 4) ? ((MEM_T_RL - 4) / 2) : 0;
	localparam int OCT_OFF_DELAY = (MEM_T_RL + 6) / 2;

	// Retimed full enable, counted as tap 0 of the window
	logic                     en_full_q;

	// Older copies of the full enable, tap i+1 sits in bit i
	logic [OCT_OFF_DELAY-1:0] en_full_shift;

	// All taps side by side so the window is a plain slice
	logic [OCT_OFF_DELAY:0]   en_full_taps;

	// High while any read burst is expected on the bus
	logic                     read_window;

	assign en_full_taps = {en_full_shift, en_full_q};

	// Overlapping reads simply merge into one longer window
	assign read_window = |en_full_taps[OCT_OFF_DELAY:OCT_ON_DELAY];

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			en_full_q       <= 1'b0;
			en_full_shift   <= '0;
			// termination held on during reset
			force_oct_off_o <= '0;
		end
		else
		begin
			// Only phase 0 matters since a full enable spans the AFI cycle
			en_full_q     <= afi_rdata_en_full_i[0];
			en_full_shift <= {en_full_shift[OCT_OFF_DELAY-2:0], en_full_q};

			// Every group shares the same window
			force_oct_off_o <= {AFI_DQS_WIDTH{~read_window}};
		end
	end

endmodule

`default_nettype wire

// File: rtl/read_latency_fifo.sv
`default_nettype none

module read_latency_fifo #(
	parameter int EXTRA_VFIFO_SHIFT = 0
) (
	input  logic                          pll_afi_clk,
	input  logic                          reset_n_afi_clk,
	input  read_datapath_pkg::rate_mask_t afi_rdata_en_i,
	input  read_datapath_pkg::lat_cnt_t   seq_read_latency_counter_i,
	output read_datapath_pkg::rate_mask_t afi_rdata_valid_o
);

	import read_datapath_pkg::*;

	// Read enable after the optional extra delay
	rate_mask_t en_dly;

	// ********************
	// Extra enable delay
	// ********************

	// Adds a fixed number of AFI cycles in front of the latency shifter
	// Zero cycles leaves the enable untouched and builds no flops
	generate
		if (EXTRA_VFIFO_SHIFT > 0)
		begin : g_extra_shift
			// Stage 0 holds the newest enable, the last stage feeds the shifter
			rate_mask_t [EXTRA_VFIFO_SHIFT-1:0] en_pipe;

			always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
			begin
				if (!reset_n_afi_clk)
				begin
					en_pipe <= '0;
				end
				else
				begin
					en_pipe[0] <= afi_rdata_en_i;
					for (int i = 1; i < EXTRA_VFIFO_SHIFT; i++)
						en_pipe[i] <= en_pipe[i-1];
				end
			end

			assign en_dly = en_pipe[EXTRA_VFIFO_SHIFT-1];
		end
		else
		begin : g_no_shift
			assign en_dly = afi_rdata_en_i;
		end
	endgenerate

	// ********************
	// Latency shifters
	// ********************

	// In half rate each enable covers both phases of the AFI cycle
	// Every phase therefore tracks enable bit 0 and the other bit plays no part
	// The phases stay separate so each valid bit has its own flop near its sink
	generate
		for (genvar p = 0; p < AFI_RATE_RATIO; p++)
		begin : g_phase
			// Bit j holds the enable that entered j cycles ago
			logic [MAX_READ_LATENCY-1:0] lat_shift;

			// Tap chosen by the sequencer, registered once
			logic                        sel_valid;

			// Final valid flop that drives the AFI
			logic                        valid_q;

			always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
			begin
				if (!reset_n_afi_clk)
				begin
					lat_shift <= '0;
					sel_valid <= 1'b0;
					valid_q   <= 1'b0;
				end
				else
				begin
					// A new enable can enter every cycle so many reads overlap
					lat_shift <= {lat_shift[MAX_READ_LATENCY-2:0], en_dly[0]};

					// The counter is static after calibration, so this mux
					// behaves like a fixed tap during normal traffic
					sel_valid <= lat_shift[seq_read_latency_counter_i];

					valid_q <= sel_valid;
				end
			end

			assign afi_rdata_valid_o[p] = valid_q;
		end
	endgenerate

endmodule

`default_nettype wire

// File: rtl/read_datapath_pkg.sv
`default_nettype none

package read_datapath_pkg;

	// ********************
	// Interface geometry
	// ********************

	// Memory data bits summed over all read DQS groups
	localparam int MEM_DQ_WIDTH = 16;

	// Number of read DQS groups on the interface
	localparam int MEM_READ_DQS_WIDTH = 2;

	// Data bits captured by a single DQS group
	localparam int DQ_GROUP_WIDTH = MEM_DQ_WIDTH / MEM_READ_DQS_WIDTH;

	// Half rate controller, so two AFI phases per AFI clock
	localparam int AFI_RATE_RATIO = 2;

	// DDR gives two memory beats per memory clock, so four slots per AFI cycle
	localparam int NUM_TIMESLOTS = 2 * AFI_RATE_RATIO;

	// Read data carried across the AFI in one AFI cycle
	localparam int AFI_DATA_WIDTH = MEM_DQ_WIDTH * NUM_TIMESLOTS;

	// One termination control bit per DQS group
	localparam int AFI_DQS_WIDTH = 2;

	// ********************
	// Read latency depths
	// ********************

	// Depth of the read enable shifter, which bounds the calibrated latency
	localparam int MAX_READ_LATENCY = 32;

	// Enough bits to name any tap of the shifter
	localparam int LAT_CNT_WIDTH = $clog2(MAX_READ_LATENCY);

	// Capture bus, AFI read data and the sequencer copy all share this width
	typedef logic [AFI_DATA_WIDTH-1:0] afi_data_t;

	// One bit per AFI phase
	typedef logic [AFI_RATE_RATIO-1:0] rate_mask_t;

	// Read latency in AFI cycles as tuned by the sequencer
	typedef logic [LAT_CNT_WIDTH-1:0] lat_cnt_t;

	// One bit per termination controlled group
	typedef logic [AFI_DQS_WIDTH-1:0] oct_mask_t;

endpackage

`default_nettype wire
